/* hw/hawk_macros.svh */
// widths, table base addresses, page status codes and the wait limit
// for the page read manager

`ifndef HAWK_MACROS_SVH
`define HAWK_MACROS_SVH

`define HAWK_ADDR_W     40  // byte address
`define HAWK_DATA_W     64  // one read beat
`define HAWK_WAY_W      28  // page frame number, addr[39:12]
`define HAWK_LST_IDX_W  8   // free list index, 0 is null
`define HAWK_ZPD_W      8   // zero page count
`define HAWK_STS_W      2
`define HAWK_RESP_W     2

`define HAWK_ATT_BASE   40'h00_C000_0000  // ATT entry 0
`define HAWK_TOL_BASE   40'h00_C100_0000  // TOL entry 0
`define HAWK_HPPA_BASE  28'h008_0000      // first host page number

// page status in an ATT entry
`define HAWK_STS_DALLOC 2'd0
`define HAWK_STS_UNCOMP 2'd1
`define HAWK_STS_INCOMP 2'd2
`define HAWK_STS_COMP   2'd3

`define HAWK_WAIT_MAX   64  // cycles before a wait counts as a bus error

`endif

/* hw/hawk_pkg.sv */
// table entry layouts and the read word union
// a fetched word is either an ATT entry or a TOL free list entry

`include "hawk_macros.svh"

package hawk_pkg;

  // address translation table entry
  typedef struct packed {
    logic [`HAWK_DATA_W-`HAWK_ZPD_W-`HAWK_STS_W-`HAWK_WAY_W-1:0] rsvd;
    logic [`HAWK_ZPD_W-1:0]                                       zpd_cnt;  // zero block writes seen
    logic [`HAWK_STS_W-1:0]                                       sts;
    logic [`HAWK_WAY_W-1:0]                                       way;      // frame or compressed location
  } att_entry_t;

  // free list entry in the TOL
  typedef struct packed {
    logic [`HAWK_DATA_W-`HAWK_LST_IDX_W-`HAWK_WAY_W-1:0] rsvd;
    logic [`HAWK_LST_IDX_W-1:0]                          nxt_idx;  // link to the next entry
    logic [`HAWK_WAY_W-1:0]                              way;      // free frame
  } lst_entry_t;

  // the same 64 bit beat, decoded by which table was read
  typedef union packed {
    att_entry_t att;
    lst_entry_t lst;
  } rd_word_u;

endpackage

/* hw/hawk_rd_if.sv */
// internal read request/result between the page read FSM and the AXI read port

`include "hawk_macros.svh"

interface hawk_rd_if
  import hawk_pkg::*;
();

  logic                       rd_start;  // one cycle, only with no read outstanding
  logic                       rd_tol;    // 1 reads the TOL, 0 the ATT
  logic [`HAWK_WAY_W-1:0]     att_id;
  logic [`HAWK_LST_IDX_W-1:0] lst_idx;

  logic                       rd_done;   // clean response
  logic                       rd_err;    // nonzero rresp
  rd_word_u                   rd_word;   // held until the next beat

  modport fsm (output rd_start, rd_tol, att_id, lst_idx, input rd_done, rd_err);

  modport port (input rd_start, rd_tol, att_id, lst_idx, output rd_done, rd_err, rd_word);

endinterface

/* hw/hawk_pgrd_fsm.sv */
// page read manager FSM
// sequences ATT lookup, free list pop, table update, compress and decompress

`include "hawk_macros.svh"

module hawk_pgrd_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       lookup,
  input  logic [`HAWK_WAY_W-1:0]     hppa,
  input  logic                       zero_blk_wr,
  input  logic [`HAWK_LST_IDX_W-1:0] free_head,
  input  logic [`HAWK_LST_IDX_W-1:0] uncomp_head,
  input  logic [`HAWK_LST_IDX_W-1:0] uncomp_tail,
  input  logic                       pgwr_ready,
  input  logic                       tbl_update_done,
  input  logic                       comp_done,
  input  logic                       decomp_done,
  input  logic                       expired,
  input  logic [`HAWK_STS_W-1:0]     att_sts,
  input  logic [`HAWK_ZPD_W-1:0]     att_zpd_cnt,
  hawk_rd_if.fsm                     rd,
  output logic                       wait_run,
  output logic                       att_load,
  output logic                       lst_load,
  output logic                       grant,
  output logic                       upd_fire,
  output logic                       zpd_only,
  output logic                       comp_load,
  output logic                       dec_load,
  output logic                       comp_start,
  output logic                       decomp_start,
  output logic                       pgrd_ready,
  output logic                       bus_error
);

  localparam logic [3:0] IDLE       = 4'd0;
  localparam logic [3:0] READ_ATT   = 4'd1;
  localparam logic [3:0] CHK_ATT    = 4'd2;
  localparam logic [3:0] POP_FREE   = 4'd3;
  localparam logic [3:0] READ_LST   = 4'd4;
  localparam logic [3:0] TBL_UPDATE = 4'd5;
  localparam logic [3:0] TBL_WAIT   = 4'd6;
  localparam logic [3:0] COMPRESS   = 4'd7;
  localparam logic [3:0] DECOMPRESS = 4'd8;
  localparam logic [3:0] BUS_ERROR  = 4'd9;

  logic [3:0]             state, state_n;
  logic                   st_new;     // first cycle in a state, timer held clear
  logic                   was_comp;   // looked up page sits compressed
  logic                   via_comp;   // free way came from the compressor
  logic                   fault;
  logic                   is_hit;
  logic [`HAWK_WAY_W-1:0] att_id_q;
  logic [`HAWK_WAY_W-1:0] att_id_new;

  assign att_id_new = hppa - `HAWK_HPPA_BASE + 1'b1;  // entry ids start at 1
  assign is_hit     = (att_sts == `HAWK_STS_UNCOMP) || (att_sts == `HAWK_STS_INCOMP);

  // every state that waits on memory or an agent is timed
  assign wait_run = !st_new && (state == READ_ATT || state == READ_LST ||
                                state == TBL_UPDATE || state == TBL_WAIT ||
                                state == COMPRESS || state == DECOMPRESS);
  assign fault    = rd.rd_err || (expired && wait_run);

  assign rd.rd_tol  = (state == POP_FREE);
  assign rd.att_id  = (state == IDLE) ? att_id_new : att_id_q;  // address forms with rd_start
  assign rd.lst_idx = free_head;

  assign pgrd_ready = (state == IDLE);
  assign bus_error  = (state == BUS_ERROR);  // sticky, only reset leaves it

  always_comb begin
    state_n     = state;
    rd.rd_start = 1'b0;
    att_load    = 1'b0;
    lst_load    = 1'b0;
    grant       = 1'b0;
    upd_fire    = 1'b0;
    zpd_only    = 1'b0;
    comp_load   = 1'b0;
    dec_load    = 1'b0;
    if (fault) begin
      state_n = BUS_ERROR;
    end else begin
      case (state)
        IDLE: if (lookup) begin
          rd.rd_start = 1'b1;
          state_n     = READ_ATT;
        end
        READ_ATT: if (rd.rd_done) begin
          att_load = 1'b1;
          state_n  = CHK_ATT;
        end
        CHK_ATT: begin
          if (is_hit) begin
            if (zero_blk_wr && att_zpd_cnt != '1) begin  // count saturates
              zpd_only = 1'b1;
              state_n  = TBL_UPDATE;
            end else begin
              grant   = 1'b1;
              state_n = IDLE;
            end
          end else begin
            state_n = POP_FREE;  // dalloc or compressed both need a free way
          end
        end
        POP_FREE: begin
          if (free_head != '0) begin
            rd.rd_start = 1'b1;
            state_n     = READ_LST;
          end else if (uncomp_head != uncomp_tail) begin
            state_n = COMPRESS;  // two or more uncompressed pages to squeeze
          end else begin
            state_n = IDLE;  // nothing to give, lookup ends without grant
          end
        end
        READ_LST: if (rd.rd_done) begin
          lst_load = 1'b1;
          dec_load = was_comp;
          state_n  = was_comp ? DECOMPRESS : TBL_UPDATE;
        end
        TBL_UPDATE: if (pgwr_ready) begin  // back-pressure from the write manager
          upd_fire = 1'b1;
          state_n  = TBL_WAIT;
        end
        TBL_WAIT: if (tbl_update_done) begin
          grant   = 1'b1;
          state_n = IDLE;
        end
        COMPRESS: if (comp_done) begin
          comp_load = 1'b1;
          if (was_comp) begin
            dec_load = 1'b1;  // expand into the way just freed
            state_n  = DECOMPRESS;
          end else begin
            grant   = 1'b1;
            state_n = IDLE;
          end
        end
        DECOMPRESS: if (decomp_done) begin
          if (via_comp) begin
            grant   = 1'b1;  // compressor already updated its tables
            state_n = IDLE;
          end else begin
            state_n = TBL_UPDATE;
          end
        end
        BUS_ERROR: state_n = BUS_ERROR;
        default:   state_n = BUS_ERROR;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state        <= IDLE;
      st_new       <= 1'b0;
      was_comp     <= 1'b0;
      via_comp     <= 1'b0;
      comp_start   <= 1'b0;
      decomp_start <= 1'b0;
    end else begin
      state        <= state_n;
      st_new       <= (state_n != state);
      comp_start   <= (state_n == COMPRESS) && (state != COMPRESS);  // pulse on entry
      decomp_start <= (state_n == DECOMPRESS) && (state != DECOMPRESS);
      if (state == CHK_ATT) was_comp <= (att_sts == `HAWK_STS_COMP);
      if (state == IDLE) begin
        via_comp <= 1'b0;
      end else if (comp_load) begin
        via_comp <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == IDLE && lookup) att_id_q <= att_id_new;
  end

endmodule

/* hw/hawk_wait_timer.sv */
// wait timer, flags a wait that has run for the full limit

`include "hawk_macros.svh"

module hawk_wait_timer (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic wait_run,  // level, low clears the count
  output logic expired
);

  localparam int CNT_W = $clog2(`HAWK_WAIT_MAX + 1);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt     <= '0;
      expired <= 1'b0;
    end else if (!wait_run) begin
      cnt     <= '0;
      expired <= 1'b0;
    end else begin
      if (cnt != CNT_W'(`HAWK_WAIT_MAX)) cnt <= cnt + 1'b1;  // saturate
      // high once the limit of consecutive cycles has been seen
      expired <= (cnt >= CNT_W'(`HAWK_WAIT_MAX - 1));
    end
  end

endmodule

/* hw/hawk_rd_port.sv */
// single beat AXI read port
// forms ATT/TOL addresses, holds arvalid, captures and classifies the beat

`include "hawk_macros.svh"

module hawk_rd_port (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    arready,
  input  logic                    rvalid,
  input  logic                    rlast,
  input  logic [`HAWK_DATA_W-1:0] rdata,
  input  logic [`HAWK_RESP_W-1:0] rresp,
  hawk_rd_if.port                 rd,
  output logic                    arvalid,
  output logic [`HAWK_ADDR_W-1:0] araddr,
  output logic                    rready
);

  logic                    outst;  // read issued, beat not yet back
  logic                    beat;
  logic [`HAWK_ADDR_W-1:0] addr_n;

  assign beat   = outst && rvalid && rlast;  // arlen is 0, one beat only
  assign rready = outst;

  // entries are 8 bytes
  always_comb begin
    if (rd.rd_tol) begin
      addr_n = `HAWK_TOL_BASE +
               {{(`HAWK_ADDR_W-`HAWK_LST_IDX_W-3){1'b0}}, rd.lst_idx, 3'b000};
    end else begin
      addr_n = `HAWK_ATT_BASE +
               {{(`HAWK_ADDR_W-`HAWK_WAY_W-3){1'b0}}, rd.att_id, 3'b000};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      arvalid    <= 1'b0;
      outst      <= 1'b0;
      rd.rd_done <= 1'b0;
      rd.rd_err  <= 1'b0;
    end else begin
      if (rd.rd_start) begin
        arvalid <= 1'b1;
        outst   <= 1'b1;
      end else begin
        if (arvalid && arready) arvalid <= 1'b0;  // accepted
        if (beat) outst <= 1'b0;
      end
      rd.rd_done <= beat && (rresp == '0);
      rd.rd_err  <= beat && (rresp != '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd.rd_start) araddr <= addr_n;
    if (beat) rd.rd_word <= rdata;
  end

endmodule

/* hw/hawk_entry_regs.sv */
// entry registers
// decodes the fetched word, builds the translation, update record and
// decompress addresses

`include "hawk_macros.svh"

module hawk_entry_regs
  import hawk_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  rd_word_u                   rd_word,
  input  logic [`HAWK_WAY_W-1:0]     att_id,
  input  logic                       zero_blk_wr,
  input  logic [`HAWK_WAY_W-1:0]     comp_way,
  input  logic                       att_load,
  input  logic                       lst_load,
  input  logic                       grant,
  input  logic                       upd_fire,
  input  logic                       zpd_only,
  input  logic                       comp_load,
  input  logic                       dec_load,
  output logic [`HAWK_STS_W-1:0]     att_sts,
  output logic [`HAWK_ZPD_W-1:0]     att_zpd_cnt,
  output logic                       allow_access,
  output logic [`HAWK_ADDR_W-1:0]    ppa,
  output logic [`HAWK_STS_W-1:0]     sts,
  output logic                       tbl_update,
  output logic [`HAWK_WAY_W-1:0]     upd_att_id,
  output logic [`HAWK_WAY_W-1:0]     upd_way,
  output logic [`HAWK_STS_W-1:0]     upd_sts,
  output logic [`HAWK_ZPD_W-1:0]     upd_zpd_cnt,
  output logic [`HAWK_ADDR_W-1:0]    decomp_src,
  output logic [`HAWK_ADDR_W-1:0]    decomp_dst
);

  att_entry_t             att_q;    // looked up entry
  logic [`HAWK_WAY_W-1:0] gnt_way;  // way handed out on grant
  logic [`HAWK_STS_W-1:0] gnt_sts;
  logic [`HAWK_WAY_W-1:0] dst_way;

  assign att_sts     = att_q.sts;
  assign att_zpd_cnt = att_q.zpd_cnt;
  assign dst_way     = comp_load ? comp_way : rd_word.lst.way;  // compressor or popped way

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      allow_access <= 1'b0;
      tbl_update   <= 1'b0;
    end else begin
      allow_access <= grant;
      tbl_update   <= upd_fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (att_load) begin
      att_q      <= rd_word.att;
      gnt_way    <= rd_word.att.way;  // plain hit keeps its frame
      gnt_sts    <= rd_word.att.sts;
      upd_att_id <= att_id;
    end
    if (lst_load) begin
      gnt_way     <= rd_word.lst.way;
      gnt_sts     <= `HAWK_STS_UNCOMP;
      upd_way     <= rd_word.lst.way;  // allocation record
      upd_sts     <= `HAWK_STS_UNCOMP;
      upd_zpd_cnt <= zero_blk_wr ? `HAWK_ZPD_W'(1) : '0;
    end
    if (zpd_only) begin
      upd_way     <= att_q.way;
      upd_sts     <= att_q.sts;  // status unchanged, only count bumps
      upd_zpd_cnt <= att_q.zpd_cnt + 1'b1;
    end
    if (comp_load) begin
      gnt_way <= comp_way;
      gnt_sts <= `HAWK_STS_UNCOMP;
    end
    if (dec_load) begin
      decomp_src <= {att_q.way, 12'h000};  // compressed page location
      decomp_dst <= {dst_way, 12'h000};
    end
    if (grant) begin
      // compressor way may arrive in the same cycle as the grant
      ppa <= {(comp_load ? comp_way : gnt_way), 12'h000};
      sts <= comp_load ? `HAWK_STS_UNCOMP : gnt_sts;
    end
  end

endmodule

/* hw/hawk_pgrd_top.sv */
// page read manager top level
// FSM, wait timer, AXI read port and entry registers on plain ports

`include "hawk_macros.svh"

module hawk_pgrd_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       lookup,
  input  logic [`HAWK_WAY_W-1:0]     hppa,
  input  logic                       zero_blk_wr,
  input  logic [`HAWK_LST_IDX_W-1:0] free_head,
  input  logic [`HAWK_LST_IDX_W-1:0] uncomp_head,
  input  logic [`HAWK_LST_IDX_W-1:0] uncomp_tail,
  input  logic                       pgwr_ready,
  input  logic                       tbl_update_done,
  input  logic                       comp_done,
  input  logic [`HAWK_WAY_W-1:0]     comp_way,
  input  logic                       decomp_done,
  output logic                       arvalid,
  input  logic                       arready,
  output logic [`HAWK_ADDR_W-1:0]    araddr,
  input  logic                       rvalid,
  input  logic                       rlast,
  input  logic [`HAWK_DATA_W-1:0]    rdata,
  input  logic [`HAWK_RESP_W-1:0]    rresp,
  output logic                       rready,
  output logic                       allow_access,
  output logic [`HAWK_ADDR_W-1:0]    ppa,
  output logic [`HAWK_STS_W-1:0]     sts,
  output logic                       tbl_update,
  output logic [`HAWK_WAY_W-1:0]     upd_att_id,
  output logic [`HAWK_WAY_W-1:0]     upd_way,
  output logic [`HAWK_STS_W-1:0]     upd_sts,
  output logic [`HAWK_ZPD_W-1:0]     upd_zpd_cnt,
  output logic                       comp_start,
  output logic                       decomp_start,
  output logic [`HAWK_ADDR_W-1:0]    decomp_src,
  output logic [`HAWK_ADDR_W-1:0]    decomp_dst,
  output logic                       pgrd_ready,
  output logic                       bus_error
);

  logic                   wait_run, expired;
  logic                   att_load, lst_load, grant, upd_fire;
  logic                   zpd_only, comp_load, dec_load;
  logic [`HAWK_STS_W-1:0] att_sts;
  logic [`HAWK_ZPD_W-1:0] att_zpd_cnt;

  hawk_rd_if i_rd ();  // FSM to read port

  hawk_pgrd_fsm i_fsm (
    .clk_i, .rst_ni, .lookup, .hppa, .zero_blk_wr, .free_head, .uncomp_head,
    .uncomp_tail, .pgwr_ready, .tbl_update_done, .comp_done, .decomp_done,
    .expired, .att_sts, .att_zpd_cnt, .rd(i_rd.fsm), .wait_run, .att_load,
    .lst_load, .grant, .upd_fire, .zpd_only, .comp_load, .dec_load,
    .comp_start, .decomp_start, .pgrd_ready, .bus_error
  );

  hawk_wait_timer i_timer (.clk_i, .rst_ni, .wait_run, .expired);

  hawk_rd_port i_port (
    .clk_i, .rst_ni, .arready, .rvalid, .rlast, .rdata, .rresp,
    .rd(i_rd.port), .arvalid, .araddr, .rready
  );

  hawk_entry_regs i_regs (
    .clk_i, .rst_ni, .rd_word(i_rd.rd_word), .att_id(i_rd.att_id), .zero_blk_wr,
    .comp_way, .att_load, .lst_load, .grant, .upd_fire, .zpd_only, .comp_load,
    .dec_load, .att_sts, .att_zpd_cnt, .allow_access, .ppa, .sts, .tbl_update,
    .upd_att_id, .upd_way, .upd_sts, .upd_zpd_cnt, .decomp_src, .decomp_dst
  );

endmodule

/* bench/hawk_clk_gen.sv */
// clock and power-on reset for the page read manager testbench

module hawk_clk_gen (
  output logic clk_i,
  output logic rst_ni
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    repeat (16) @(posedge clk_i);  // reset held 16 cycles
    #10 rst_ni = 1'b1;
  end

  always #50 clk_i = ~clk_i;  // 100 ns period

endmodule

/* bench/hawk_pgrd_chk.sv */
// protocol assertions on the page read manager ports
// bound into hawk_pgrd_top

module hawk_pgrd_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic arvalid,
  input logic arready,
  input logic allow_access,
  input logic tbl_update,
  input logic bus_error,
  input logic pgrd_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;  // failed assertions so far

  // request stays up until the slave takes it
  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    arvalid && !arready |=> arvalid)
    else begin
      fail_cnt++;
      $error("arvalid dropped before arready");
    end

  a_gnt_upd: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(allow_access && tbl_update))
    else begin
      fail_cnt++;
      $error("allow_access and tbl_update together");
    end

  a_err_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_error |=> bus_error)
    else begin
      fail_cnt++;
      $error("bus_error fell without reset");
    end

  a_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    arvalid |-> !pgrd_ready)
    else begin
      fail_cnt++;
      $error("pgrd_ready high during a read");
    end

endmodule

bind hawk_pgrd_top hawk_pgrd_chk i_chk (.*);

/* bench/hawk_pgrd_tb.sv */
// directed tests for the page read manager
// memory, write agent and compressor agents, compare tasks and the verdict

`include "hawk_macros.svh"

module hawk_pgrd_tb
  import hawk_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  logic clk_i, rst_gen, rst_tb, rst_ni;
  logic lookup, zero_blk_wr, pgwr_ready, tbl_update_done, comp_done, decomp_done;
  logic [`HAWK_WAY_W-1:0]     hppa, comp_way, upd_att_id, upd_way;
  logic [`HAWK_LST_IDX_W-1:0] free_head, uncomp_head, uncomp_tail;
  logic arvalid, arready, rvalid, rlast, rready, allow_access, tbl_update;
  logic comp_start, decomp_start, pgrd_ready, bus_error;
  logic [`HAWK_ADDR_W-1:0] araddr, ppa, decomp_src, decomp_dst;
  logic [`HAWK_DATA_W-1:0] rdata;
  logic [`HAWK_RESP_W-1:0] rresp;
  logic [`HAWK_STS_W-1:0]  sts, upd_sts;
  logic [`HAWK_ZPD_W-1:0]  upd_zpd_cnt;

  logic [`HAWK_DATA_W-1:0] att_mem [256];  // indexed by entry id
  logic [`HAWK_DATA_W-1:0] tol_mem [256];  // indexed by list index
  logic [`HAWK_ADDR_W-1:0] addr_q [$];     // every accepted araddr
  bit mem_err, mem_drop;
  int err_cnt;
  // results seen during one lookup
  int n_grant, n_upd, n_comp, n_dec;
  bit err_seen;
  logic [`HAWK_ADDR_W-1:0] got_ppa, got_src, got_dst;
  logic [`HAWK_STS_W-1:0]  got_sts, got_usts;
  logic [`HAWK_WAY_W-1:0]  got_id, got_way;
  logic [`HAWK_ZPD_W-1:0]  got_zpd;

  assign rst_ni = rst_gen & rst_tb;

  hawk_clk_gen i_clk (.clk_i, .rst_ni(rst_gen));

  hawk_pgrd_top i_dut (.*);

  function automatic logic [`HAWK_DATA_W-1:0] make_att(
    input logic [`HAWK_ZPD_W-1:0] zpd, input logic [`HAWK_STS_W-1:0] s,
    input logic [`HAWK_WAY_W-1:0] way);
    att_entry_t e;
    e = '0;
    e.zpd_cnt = zpd;
    e.sts     = s;
    e.way     = way;
    return e;
  endfunction

  function automatic logic [`HAWK_DATA_W-1:0] make_lst(
    input logic [`HAWK_LST_IDX_W-1:0] nxt, input logic [`HAWK_WAY_W-1:0] way);
    lst_entry_t e;
    e = '0;
    e.nxt_idx = nxt;
    e.way     = way;
    return e;
  endfunction

  // memory model, table picked by base address
  function automatic logic [`HAWK_DATA_W-1:0] read_mem(input logic [`HAWK_ADDR_W-1:0] a);
    if (a >= `HAWK_TOL_BASE) return tol_mem[8'((a - `HAWK_TOL_BASE) >> 3)];
    return att_mem[8'((a - `HAWK_ATT_BASE) >> 3)];
  endfunction

  function automatic logic [`HAWK_WAY_W-1:0] id_of(input logic [`HAWK_WAY_W-1:0] h);
    return h - `HAWK_HPPA_BASE + 1;  // ids start at 1
  endfunction

  // true when the slave took a read at this address
  function automatic bit addr_seen(input logic [`HAWK_ADDR_W-1:0] a);
    foreach (addr_q[i]) begin
      if (addr_q[i] == a) return 1'b1;
    end
    return 1'b0;
  endfunction

  // AXI read slave, one beat per request
  initial begin
    logic [`HAWK_ADDR_W-1:0] a;
    forever begin
      @(posedge clk_i);
      if (arvalid && rst_ni) begin
        a = araddr;
        repeat ($urandom_range(5, 0)) @(posedge clk_i);
        #10 arready = 1'b1;
        @(posedge clk_i);
        #10 arready = 1'b0;
        addr_q.push_back(a);
        if (!mem_drop) begin
          repeat ($urandom_range(5, 0)) @(posedge clk_i);
          #10;
          rvalid = 1'b1;
          rlast  = 1'b1;
          rdata  = read_mem(a);
          rresp  = mem_err ? 2'd2 : 2'd0;  // slverr
          if (rready !== 1'b1) report("rready low while the read beat is offered");
          @(posedge clk_i);
          #10 rvalid = 1'b0;
          rlast = 1'b0;
        end
      end
    end
  end

  // page write manager agent
  always begin
    @(posedge clk_i);
    if (tbl_update) begin
      repeat ($urandom_range(5, 0)) @(posedge clk_i);
      #10 tbl_update_done = 1'b1;
      @(posedge clk_i);
      #10 tbl_update_done = 1'b0;
    end
  end

  // compressor and decompressor agents
  always begin
    @(posedge clk_i);
    if (comp_start) begin
      repeat ($urandom_range(5, 0)) @(posedge clk_i);
      #10 comp_done = 1'b1;
      @(posedge clk_i);
      #10 comp_done = 1'b0;
    end
  end

  always begin
    @(posedge clk_i);
    if (decomp_start) begin
      repeat ($urandom_range(5, 0)) @(posedge clk_i);
      #10 decomp_done = 1'b1;
      @(posedge clk_i);
      #10 decomp_done = 1'b0;
    end
  end

  task automatic report(input string msg);
    err_cnt++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) report($sformatf("%s count %0d, expected %0d", what, got, exp));
  endtask

  task automatic check_translation(input logic [`HAWK_ADDR_W-1:0] exp_ppa,
                                   input logic [`HAWK_STS_W-1:0] exp_sts);
    if (n_grant != 1) report($sformatf("%0d grants, expected 1", n_grant));
    else if (got_ppa !== exp_ppa || got_sts !== exp_sts)
      report($sformatf("ppa %h sts %0d, expected %h %0d", got_ppa, got_sts, exp_ppa, exp_sts));
  endtask

  task automatic check_update(input logic [`HAWK_WAY_W-1:0] exp_id,
                              input logic [`HAWK_WAY_W-1:0] exp_way,
                              input logic [`HAWK_STS_W-1:0] exp_sts,
                              input logic [`HAWK_ZPD_W-1:0] exp_zpd);
    if (n_upd != 1) report($sformatf("%0d table updates, expected 1", n_upd));
    else if (got_id !== exp_id || got_way !== exp_way || got_usts !== exp_sts ||
             got_zpd !== exp_zpd)
      report($sformatf("update id %h way %h sts %0d zpd %0d, expected %h %h %0d %0d",
                       got_id, got_way, got_usts, got_zpd, exp_id, exp_way, exp_sts, exp_zpd));
  endtask

  task automatic check_decomp(input logic [`HAWK_ADDR_W-1:0] exp_src,
                              input logic [`HAWK_ADDR_W-1:0] exp_dst);
    if (n_dec != 1) report($sformatf("%0d decompress starts, expected 1", n_dec));
    else if (got_src !== exp_src || got_dst !== exp_dst)
      report($sformatf("decomp %h -> %h, expected %h -> %h", got_src, got_dst, exp_src, exp_dst));
  endtask

  // out of reset and idle, returns 10 ns after an edge
  task automatic wait_ready();
    int t;
    t = 0;
    do begin
      @(posedge clk_i);
      #10;
      t++;
    end while ((pgrd_ready !== 1'b1 || rst_ni !== 1'b1) && t < 200);
    if (pgrd_ready !== 1'b1 || rst_ni !== 1'b1) report("DUT never became ready");
  endtask

  // issue one lookup and record everything until pgrd_ready or bus_error
  task automatic run_lookup(input logic [`HAWK_WAY_W-1:0] h, input logic zb);
    int t;
    n_grant  = 0;
    n_upd    = 0;
    n_comp   = 0;
    n_dec    = 0;
    err_seen = 0;
    wait_ready();
    lookup      = 1'b1;
    hppa        = h;
    zero_blk_wr = zb;
    @(posedge clk_i);
    #10 lookup = 1'b0;
    for (t = 0; t < 1000; t++) begin
      @(posedge clk_i);
      #10;
      if (tbl_update) begin
        n_upd++;
        got_id   = upd_att_id;
        got_way  = upd_way;
        got_usts = upd_sts;
        got_zpd  = upd_zpd_cnt;
      end
      if (comp_start) n_comp++;
      if (decomp_start) begin
        n_dec++;
        got_src = decomp_src;
        got_dst = decomp_dst;
      end
      if (allow_access) begin
        n_grant++;
        got_ppa = ppa;
        got_sts = sts;
      end
      if (bus_error) err_seen = 1;
      if (pgrd_ready || bus_error) break;
    end
    if (t == 1000) report("lookup did not finish");
  endtask

  task automatic reset_dut();
    @(posedge clk_i);
    #10 rst_tb = 1'b0;
    repeat (16) @(posedge clk_i);
    #10 rst_tb = 1'b1;
  endtask

  task automatic test_hit(input logic [`HAWK_STS_W-1:0] s, input logic zb);
    logic [`HAWK_WAY_W-1:0] h;
    h = `HAWK_HPPA_BASE + 10;
    att_mem[id_of(h)] = make_att(8'd3, s, 28'h12_3456);
    run_lookup(h, zb);
    if (zb) check_update(id_of(h), 28'h12_3456, s, 8'd4);
    else check_count(n_upd, 0, "table update on hit");
    check_translation({28'h12_3456, 12'h000}, s);
  endtask

  task automatic test_dalloc(input logic zb, input bit hold);
    logic [`HAWK_WAY_W-1:0] h;
    h = `HAWK_HPPA_BASE + 21;
    att_mem[id_of(h)] = make_att(8'd0, `HAWK_STS_DALLOC, 28'h0);
    free_head  = 8'd5;
    tol_mem[5] = make_lst(8'd6, 28'h0a_bc00);
    addr_q.delete();
    pgwr_ready = !hold;
    fork
      run_lookup(h, zb);
      if (hold) begin
        repeat (40) @(posedge clk_i);
        check_count(n_upd, 0, "update under back-pressure");
        #10 pgwr_ready = 1'b1;
      end
    join
    if (!addr_seen(`HAWK_TOL_BASE + 40'(free_head) * 40'd8)) report("no TOL read at free head");
    check_update(id_of(h), 28'h0a_bc00, `HAWK_STS_UNCOMP, zb ? 8'd1 : 8'd0);
    check_translation({28'h0a_bc00, 12'h000}, `HAWK_STS_UNCOMP);
  endtask

  task automatic test_comp();
    logic [`HAWK_WAY_W-1:0] h;
    h = `HAWK_HPPA_BASE + 33;
    att_mem[id_of(h)] = make_att(8'd0, `HAWK_STS_COMP, 28'h05_5500);
    free_head  = 8'd7;
    tol_mem[7] = make_lst(8'd0, 28'h07_7700);
    run_lookup(h, 1'b0);
    check_decomp({28'h05_5500, 12'h000}, {28'h07_7700, 12'h000});
    check_update(id_of(h), 28'h07_7700, `HAWK_STS_UNCOMP, 8'd0);
    check_translation({28'h07_7700, 12'h000}, `HAWK_STS_UNCOMP);
  endtask

  task automatic test_empty(input bit can_comp);
    logic [`HAWK_WAY_W-1:0] h;
    h = `HAWK_HPPA_BASE + 40;
    att_mem[id_of(h)] = make_att(8'd0, `HAWK_STS_DALLOC, 28'h0);
    free_head   = 8'd0;
    uncomp_head = 8'd3;
    uncomp_tail = can_comp ? 8'd9 : 8'd3;
    run_lookup(h, 1'b0);
    check_count(n_comp, can_comp ? 1 : 0, "compress start");
    if (can_comp) check_translation({comp_way, 12'h000}, `HAWK_STS_UNCOMP);
    else check_count(n_grant, 0, "grant on empty list");
  endtask

  task automatic test_error(input bit drop);
    int t;
    mem_err  = !drop;
    mem_drop = drop;
    run_lookup(`HAWK_HPPA_BASE + 10, 1'b0);
    if (!err_seen) report("bus_error not raised");
    for (t = 0; t < 20; t++) begin
      @(posedge clk_i);
      #10;
      if (!bus_error || pgrd_ready) report("bus_error state left before reset");
    end
    mem_err  = 0;
    mem_drop = 0;
    reset_dut();
    test_hit(`HAWK_STS_UNCOMP, 1'b0);
  endtask

  initial begin
    void'($urandom(32'hdae5_5906));
    rst_tb          = 1;
    lookup          = 0;
    hppa            = '0;
    zero_blk_wr     = 0;
    free_head       = '0;
    uncomp_head     = '0;
    uncomp_tail     = '0;
    pgwr_ready      = 1;
    tbl_update_done = 0;
    comp_done       = 0;
    comp_way        = 28'h0c_c000;
    decomp_done     = 0;
    arready         = 0;
    rvalid          = 0;
    rlast           = 0;
    rdata           = '0;
    rresp           = '0;
    mem_err         = 0;
    mem_drop        = 0;
    err_cnt         = 0;
    for (int i = 0; i < 256; i++) begin
      att_mem[i] = {24'hA77, 40'(`HAWK_ATT_BASE + i * 8)};  // unused entries tagged by address
      tol_mem[i] = {24'h707, 40'(`HAWK_TOL_BASE + i * 8)};
    end
    wait_ready();
    test_hit(`HAWK_STS_UNCOMP, 1'b0);
    test_hit(`HAWK_STS_INCOMP, 1'b0);
    test_hit(`HAWK_STS_UNCOMP, 1'b1);
    test_dalloc(1'b0, 1'b0);
    test_dalloc(1'b1, 1'b1);
    test_comp();
    test_empty(1'b1);
    test_empty(1'b0);
    test_error(1'b0);  // slverr
    test_error(1'b1);  // silent memory
    $display("errors: %0d testbench, %0d assertion", err_cnt, i_dut.i_chk.fail_cnt);
    if (err_cnt == 0 && i_dut.i_chk.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* hawk_pgrd_top.f */
+incdir+hw
hw/hawk_pkg.sv
hw/hawk_rd_if.sv
hw/hawk_pgrd_fsm.sv
hw/hawk_wait_timer.sv
hw/hawk_rd_port.sv
hw/hawk_entry_regs.sv
hw/hawk_pgrd_top.sv
bench/hawk_clk_gen.sv
bench/hawk_pgrd_chk.sv
bench/hawk_pgrd_tb.sv
